// ==== design/uart_link_pkg.sv ====
// serial string link shared constants
// string capacity, length width, baud divider and the frame delimiter
`default_nettype none

package uart_link_pkg;

	// string capacity in bytes
	localparam int max_bytes = 16;

	// packed string port, byte k in bits 8k+7 down to 8k
	localparam int string_w = 8 * max_bytes;

	// length field holds 0 to max_bytes
	localparam int len_w = $clog2(max_bytes + 1);
	localparam logic [len_w-1:0] max_len = len_w'(max_bytes);

	// system clocks per serial bit, 4 or more
	localparam int clks_per_bit = 8;
	localparam int baud_cnt_w = $clog2(clks_per_bit);

	// last count of a bit period, and the count at mid start bit
	localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(clks_per_bit - 1);
	localparam logic [baud_cnt_w-1:0] baud_half = baud_cnt_w'(clks_per_bit / 2 - 1);

	// ASCII '&'
	localparam logic [7:0] delim_char = 8'h26;

endpackage

`default_nettype wire

// ==== design/uart_byte_tx.sv ====
// 8N1 byte serializer
// shifts start bit, eight data bits lsb first and stop bit onto txd
`timescale 1ns/1ps
`default_nettype none

module uart_byte_tx (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire  [7:0] byte_data,
	input  wire        byte_start,
	output logic       byte_done,
	output logic       txd
);

	logic [uart_link_pkg::baud_cnt_w-1:0] baud_cnt;
	logic [3:0]                           bit_idx;
	logic [9:0]                           shift_q;
	logic                                 busy;
	logic                                 bit_end;

	// last cycle of the current bit
	assign bit_end = busy && (baud_cnt == uart_link_pkg::baud_last);

	// stop bit is bit 9
	assign byte_done = bit_end && (bit_idx == 4'd9);

	// line follows the low end of the shifter, all ones when idle
	assign txd = shift_q[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_idx  <= '0;
			shift_q  <= '1;
		end else if (byte_start) begin
			// stop, data, start from msb to lsb
			busy     <= 1'b1;
			baud_cnt <= '0;
			bit_idx  <= '0;
			shift_q  <= {1'b1, byte_data, 1'b0};
		end else if (busy) begin
			if (bit_end) begin
				baud_cnt <= '0;
				// ones fill in behind, so the line idles high at the end
				shift_q  <= {1'b1, shift_q[9:1]};
				if (bit_idx == 4'd9) begin
					busy    <= 1'b0;
					bit_idx <= '0;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/uart_byte_rx.sv ====
// 8N1 byte deserializer
// synchronizes rxd, confirms the start bit at mid-bit, samples data bits
// at their centers and drops bytes with a bad stop bit
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        rxd,
	output logic [7:0] rx_byte,
	output logic       rx_byte_valid
);

	logic                                 rxd_s1;
	logic                                 rxd_s2;
	logic                                 rxd_s3;
	logic                                 fall;
	logic                                 busy;
	logic [3:0]                           bit_idx;
	logic [uart_link_pkg::baud_cnt_w-1:0] baud_cnt;
	logic [7:0]                           shift_q;
	logic                                 data_sample;

	// falling edge on the synchronized line
	assign fall = rxd_s3 && !rxd_s2;

	// bit_idx 0 is the start bit, 1 to 8 data, 9 stop
	assign data_sample = busy && (bit_idx != 4'd0) && (bit_idx != 4'd9)
		&& (baud_cnt == uart_link_pkg::baud_last);

	assign rx_byte = shift_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_s1        <= 1'b1;
			rxd_s2        <= 1'b1;
			rxd_s3        <= 1'b1;
			busy          <= 1'b0;
			bit_idx       <= '0;
			baud_cnt      <= '0;
			rx_byte_valid <= 1'b0;
		end else begin
			rxd_s1        <= rxd;
			rxd_s2        <= rxd_s1;
			rxd_s3        <= rxd_s2;
			rx_byte_valid <= 1'b0;
			if (!busy) begin
				if (fall) begin
					busy     <= 1'b1;
					baud_cnt <= '0;
					bit_idx  <= '0;
				end
			end else if (bit_idx == 4'd0) begin
				// mid start bit, a high line here was only a glitch
				if (baud_cnt == uart_link_pkg::baud_half) begin
					baud_cnt <= '0;
					if (rxd_s2) begin
						busy <= 1'b0;
					end else begin
						bit_idx <= 4'd1;
					end
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end else if (baud_cnt == uart_link_pkg::baud_last) begin
				baud_cnt <= '0;
				if (bit_idx == 4'd9) begin
					// mid stop bit, keep the byte only on a good stop
					busy          <= 1'b0;
					bit_idx       <= '0;
					rx_byte_valid <= rxd_s2;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (data_sample) begin
			shift_q <= {rxd_s2, shift_q[7:1]};
		end
	end

endmodule

`default_nettype wire

// ==== design/frame_sender.sv ====
// frame sender
// wraps up to 16 content bytes in a pair of '&' on each side and
// feeds them one at a time to the byte serializer
`timescale 1ns/1ps
`default_nettype none

module frame_sender (
	input  wire                                sys_clk,
	input  wire                                sys_rst_n,
	input  wire  [uart_link_pkg::string_w-1:0] tx_string,
	input  wire  [uart_link_pkg::len_w-1:0]    tx_length,
	input  wire                                tx_req,
	output logic                               tx_busy,
	output logic                               tx_done,
	output logic [7:0]                         byte_data,
	output logic                               byte_start,
	input  wire                                byte_done
);

	// one-hot states
	localparam logic [6:0] st_idle    = 7'b000_0001;
	localparam logic [6:0] st_dlm1    = 7'b000_0010;
	localparam logic [6:0] st_dlm2    = 7'b000_0100;
	localparam logic [6:0] st_content = 7'b000_1000;
	localparam logic [6:0] st_dlm3    = 7'b001_0000;
	localparam logic [6:0] st_dlm4    = 7'b010_0000;
	localparam logic [6:0] st_finish  = 7'b100_0000;

	logic [6:0]                         state;
	logic [uart_link_pkg::string_w-1:0] str_q;
	logic [uart_link_pkg::len_w-1:0]    len_q;
	logic [uart_link_pkg::len_w-1:0]    byte_cnt;
	logic                               accept;

	// the serializer is free again in the finish cycle
	assign accept  = tx_req && ((state == st_idle) || (state == st_finish));
	assign tx_busy = (state != st_idle) && (state != st_finish);
	assign tx_done = (state == st_finish);

	// content byte k sits in bits 8k+7 down to 8k
	assign byte_data = (state == st_content)
		? str_q[{byte_cnt[uart_link_pkg::len_w-2:0], 3'b000} +: 8]
		: uart_link_pkg::delim_char;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= st_idle;
			byte_cnt   <= '0;
			byte_start <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			case (state)
				st_idle, st_finish: begin
					if (accept) begin
						state      <= st_dlm1;
						byte_start <= 1'b1;
					end else begin
						state <= st_idle;
					end
				end
				st_dlm1: begin
					if (byte_done) begin
						state      <= st_dlm2;
						byte_start <= 1'b1;
					end
				end
				st_dlm2: begin
					if (byte_done) begin
						// empty string goes straight to the closing pair
						state      <= (len_q == '0) ? st_dlm3 : st_content;
						byte_cnt   <= '0;
						byte_start <= 1'b1;
					end
				end
				st_content: begin
					if (byte_done) begin
						byte_start <= 1'b1;
						if (byte_cnt + 1'b1 == len_q) begin
							state <= st_dlm3;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
				end
				st_dlm3: begin
					if (byte_done) begin
						state      <= st_dlm4;
						byte_start <= 1'b1;
					end
				end
				st_dlm4: begin
					if (byte_done) begin
						state <= st_finish;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request payload, lengths above capacity are clamped
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_q <= tx_string;
			len_q <= (tx_length > uart_link_pkg::max_len) ? uart_link_pkg::max_len : tx_length;
		end
	end

endmodule

`default_nettype wire

// ==== design/frame_receiver.sv ====
// frame receiver
// finds the opening '&&', stages content bytes and publishes the string
// and its length on the closing '&&', flags malformed frames
`timescale 1ns/1ps
`default_nettype none

module frame_receiver (
	input  wire                                sys_clk,
	input  wire                                sys_rst_n,
	input  wire  [7:0]                         rx_byte,
	input  wire                                rx_byte_valid,
	output logic [uart_link_pkg::string_w-1:0] rx_string,
	output logic [uart_link_pkg::len_w-1:0]    rx_length,
	output logic                               rx_busy,
	output logic                               rx_done,
	output logic                               rx_error
);

	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_one     = 2'd1;
	localparam logic [1:0] st_content = 2'd2;
	localparam logic [1:0] st_close   = 2'd3;

	logic [1:0]                         state;
	logic [uart_link_pkg::string_w-1:0] stage_q;
	logic [uart_link_pkg::len_w-1:0]    cnt;
	logic                               is_delim;
	logic                               stage_clear;
	logic                               stage_write;

	assign is_delim = (rx_byte == uart_link_pkg::delim_char);
	assign rx_busy  = (state != st_idle);

	// fresh buffer per frame so bytes above the length read as zero
	assign stage_clear = rx_byte_valid && (state == st_one) && is_delim;
	assign stage_write = rx_byte_valid && (state == st_content) && !is_delim
		&& (cnt != uart_link_pkg::max_len);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= st_idle;
			cnt       <= '0;
			rx_string <= '0;
			rx_length <= '0;
			rx_done   <= 1'b0;
			rx_error  <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (rx_byte_valid) begin
				case (state)
					st_idle: begin
						// anything but '&' between frames is ignored
						if (is_delim) begin
							state <= st_one;
						end
					end
					st_one: begin
						if (is_delim) begin
							state <= st_content;
							cnt   <= '0;
						end else begin
							state    <= st_idle;
							rx_error <= 1'b1;
						end
					end
					st_content: begin
						if (is_delim) begin
							state <= st_close;
						end else if (cnt == uart_link_pkg::max_len) begin
							// one byte past capacity
							state    <= st_idle;
							rx_error <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					st_close: begin
						state <= st_idle;
						if (is_delim) begin
							rx_done   <= 1'b1;
							rx_string <= stage_q;
							rx_length <= cnt;
						end else begin
							// lone '&' inside content
							rx_error <= 1'b1;
						end
					end
					default: state <= st_idle;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (stage_clear) begin
			stage_q <= '0;
		end else if (stage_write) begin
			stage_q[{cnt[uart_link_pkg::len_w-2:0], 3'b000} +: 8] <= rx_byte;
		end
	end

endmodule

`default_nettype wire

// ==== design/uart_string_link.sv ====
// serial string link top
// transmit lane: frame sender into byte serializer
// receive lane: byte deserializer into frame receiver
`timescale 1ns/1ps
`default_nettype none

module uart_string_link (
	input  wire                                sys_clk,
	input  wire                                sys_rst_n,
	input  wire  [uart_link_pkg::string_w-1:0] tx_string,
	input  wire  [uart_link_pkg::len_w-1:0]    tx_length,
	input  wire                                tx_req,
	output logic                               tx_busy,
	output logic                               tx_done,
	output logic [uart_link_pkg::string_w-1:0] rx_string,
	output logic [uart_link_pkg::len_w-1:0]    rx_length,
	output logic                               rx_busy,
	output logic                               rx_done,
	output logic                               rx_error,
	input  wire                                uart_rxd,
	output logic                               uart_txd
);

	// transmit lane
	logic [7:0] byte_data;
	logic       byte_start;
	logic       byte_done;

	// receive lane
	logic [7:0] rx_byte;
	logic       rx_byte_valid;

	frame_sender frame_sender_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_data  (byte_data),
		.byte_start (byte_start),
		.byte_done  (byte_done)
	);

	uart_byte_tx uart_byte_tx_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (byte_data),
		.byte_start (byte_start),
		.byte_done  (byte_done),
		.txd        (uart_txd)
	);

	uart_byte_rx uart_byte_rx_i (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rxd           (uart_rxd),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid)
	);

	frame_receiver frame_receiver_i (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_string     (rx_string),
		.rx_length     (rx_length),
		.rx_busy       (rx_busy),
		.rx_done       (rx_done),
		.rx_error      (rx_error)
	);

endmodule

`default_nettype wire

// ==== tests/tb_uart_string_link.sv ====
// testbench for the serial string link
// loopback frames and directly driven serial byte streams,
// checked against a model of the double-'&' framing
`timescale 1ns/1ps
`default_nettype none

module tb_uart_string_link;

	localparam int cpb = uart_link_pkg::clks_per_bit;
	localparam int sw = uart_link_pkg::string_w;
	localparam int lw = uart_link_pkg::len_w;
	// frame slots over all tests: 9 + 4 + 20 + 7 + 24 + 10
	localparam int planned_slots = 74;
	localparam int cycle_limit = planned_slots * (10 * cpb + 1) + 2000;

	logic          sys_clk;
	logic          sys_rst_n;
	logic [sw-1:0] tx_string;
	logic [lw-1:0] tx_length;
	logic          tx_req;
	wire           tx_busy;
	wire           tx_done;
	wire  [sw-1:0] rx_string;
	wire  [lw-1:0] rx_length;
	wire           rx_busy;
	wire           rx_done;
	wire           rx_error;
	wire           uart_rxd;
	wire           uart_txd;

	logic          loopback;
	logic          serial_rxd;
	logic [15:0]   lfsr_q;
	logic [7:0]    sent_q [$];
	logic [sw-1:0] good_string;
	logic [lw-1:0] good_length;
	int            cycle_cnt = 0;
	int            tx_done_cnt = 0;
	int            rx_done_cnt = 0;
	int            rx_error_cnt = 0;
	int            mismatch_cnt = 0;
	int            fail_cnt = 0;

	// serial input either loops the transmitter back or comes from the driver task
	assign uart_rxd = loopback ? uart_txd : serial_rxd;

	uart_string_link uart_string_link_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd)
	);

	always #50 sys_clk = ~sys_clk;

	// pulse counters, sampled mid-cycle
	always @(negedge sys_clk) begin
		if (tx_done) begin
			tx_done_cnt++;
		end
		if (rx_done) begin
			rx_done_cnt++;
		end
		if (rx_error) begin
			rx_error_cnt++;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt == cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("errors: %0d mismatches, %0d other", mismatch_cnt, fail_cnt + 1);
			$display("sim failed");
			$finish;
		end
	end

	task automatic next_edge();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_edge();
	endtask

	task automatic report_mismatch(input string name, input logic [sw-1:0] exp_v,
		input logic [sw-1:0] act_v);
		$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
		mismatch_cnt++;
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		fail_cnt++;
	endtask

	// fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		logic       fb;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			b = {fb, b[7:1]};
		end
		// keep delimiters out of content
		if (b == uart_link_pkg::delim_char) begin
			b[1] = 1'b0;
		end
		return b;
	endfunction

	// byte k of the model string in bits 8k+7 down to 8k, zero above
	function automatic logic [sw-1:0] pack_sent();
		logic [sw-1:0] s;
		s = '0;
		foreach (sent_q[k]) begin
			s[8*k +: 8] = sent_q[k];
		end
		return s;
	endfunction

	task automatic make_content(input int n);
		sent_q.delete();
		repeat (n) sent_q.push_back(rand_byte());
	endtask

	task automatic clear_counts();
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		rx_error_cnt = 0;
	endtask

	task automatic wait_pulses(input int n_tx, input int n_rx);
		while (tx_done_cnt < n_tx || rx_done_cnt < n_rx) begin
			next_edge();
		end
	endtask

	// 8N1, lsb first
	task automatic send_serial_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			serial_rxd = bits[i];
			idle_cycles(cpb);
		end
	endtask

	task automatic send_serial_frame();
		send_serial_byte(uart_link_pkg::delim_char);
		send_serial_byte(uart_link_pkg::delim_char);
		foreach (sent_q[k]) begin
			send_serial_byte(sent_q[k]);
		end
		send_serial_byte(uart_link_pkg::delim_char);
		send_serial_byte(uart_link_pkg::delim_char);
	endtask

	task automatic check_received(input logic [sw-1:0] exp_s, input logic [lw-1:0] exp_l);
		if (rx_length !== exp_l) begin
			report_mismatch("rx_length", exp_l, rx_length);
		end
		if (rx_string !== exp_s) begin
			report_mismatch("rx_string", exp_s, rx_string);
		end
	endtask

	task automatic check_rx_busy(input logic exp_b);
		if (rx_busy !== exp_b) begin
			report_mismatch("rx_busy", exp_b, rx_busy);
		end
	endtask

	task automatic check_counts(input int n_tx, input int n_rx, input int n_err);
		if (tx_done_cnt != n_tx) begin
			report_failure($sformatf("expected %0d tx_done pulses, saw %0d", n_tx, tx_done_cnt));
		end
		if (rx_done_cnt != n_rx) begin
			report_failure($sformatf("expected %0d rx_done pulses, saw %0d", n_rx, rx_done_cnt));
		end
		if (rx_error_cnt != n_err) begin
			report_failure($sformatf("expected %0d rx_error pulses, saw %0d", n_err, rx_error_cnt));
		end
	endtask

	// one-cycle request, then scramble the inputs the sender already captured
	task automatic start_request(input int n);
		tx_string = pack_sent();
		tx_length = lw'(n);
		tx_req = 1'b1;
		next_edge();
		tx_req = 1'b0;
		tx_string = '1;
		tx_length = '0;
	endtask

	task automatic test_reset_state();
		if (uart_txd !== 1'b1) begin
			report_mismatch("uart_txd", 1, uart_txd);
		end
		if ({tx_busy, tx_done, rx_busy, rx_done, rx_error} !== 5'b0) begin
			report_failure("a status output is high after reset");
		end
		check_received('0, '0);
	endtask

	task automatic test_loopback(input int n);
		loopback = 1'b1;
		make_content(n);
		clear_counts();
		start_request(n);
		wait_pulses(1, 1);
		idle_cycles(3 * cpb);
		check_counts(1, 1, 0);
		check_received(pack_sent(), lw'(n));
		good_string = pack_sent();
		good_length = lw'(n);
	endtask

	task automatic test_busy_request();
		loopback = 1'b1;
		make_content(3);
		clear_counts();
		start_request(3);
		while (!tx_busy) begin
			next_edge();
		end
		idle_cycles(20);
		// second request mid-frame with different contents
		tx_string = ~pack_sent();
		tx_length = lw'(7);
		tx_req = 1'b1;
		next_edge();
		tx_req = 1'b0;
		wait_pulses(1, 1);
		idle_cycles(2 * (10 * cpb + 1));
		if (tx_busy !== 1'b0) begin
			report_failure("transmitter busy again after an ignored request");
		end
		check_counts(1, 1, 0);
		check_received(pack_sent(), lw'(3));
		good_string = pack_sent();
		good_length = lw'(3);
	endtask

	task automatic test_bad_frames();
		loopback = 1'b0;
		// lone '&' in content
		clear_counts();
		send_serial_byte(uart_link_pkg::delim_char);
		send_serial_byte(uart_link_pkg::delim_char);
		send_serial_byte("A");
		// receiver is inside a frame now
		check_rx_busy(1'b1);
		send_serial_byte(uart_link_pkg::delim_char);
		send_serial_byte("B");
		idle_cycles(3 * cpb);
		check_counts(0, 0, 1);
		check_rx_busy(1'b0);
		check_received(good_string, good_length);
		// one byte past capacity
		clear_counts();
		make_content(17);
		send_serial_byte(uart_link_pkg::delim_char);
		send_serial_byte(uart_link_pkg::delim_char);
		foreach (sent_q[k]) begin
			send_serial_byte(sent_q[k]);
		end
		idle_cycles(3 * cpb);
		check_counts(0, 0, 1);
		check_rx_busy(1'b0);
		check_received(good_string, good_length);
	endtask

	task automatic test_recover();
		loopback = 1'b0;
		clear_counts();
		send_serial_byte(uart_link_pkg::delim_char);
		send_serial_byte("x");
		// line idles one bit time before the next frame
		idle_cycles(cpb);
		check_counts(0, 0, 1);
		make_content(4);
		send_serial_frame();
		wait_pulses(0, 1);
		idle_cycles(3 * cpb);
		check_counts(0, 1, 1);
		check_received(pack_sent(), lw'(4));
	endtask

	initial begin
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		loopback = 1'b1;
		serial_rxd = 1'b1;
		lfsr_q = 16'd56168;
		good_string = '0;
		good_length = '0;
		repeat (2) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		next_edge();
		test_reset_state();
		test_loopback(5);
		test_loopback(0);
		test_loopback(16);
		test_busy_request();
		test_bad_frames();
		test_recover();
		idle_cycles(4);
		$display("errors: %0d mismatches, %0d other", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/uart_string_link_sva.sv ====
// protocol assertions for the serial string link
// line idle level, single-cycle strobes, done and error exclusive
`timescale 1ns/1ps
`default_nettype none

module uart_string_link_sva (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire uart_txd,
	input wire tx_busy,
	input wire tx_done,
	input wire rx_done,
	input wire rx_error
);

	// line stays at idle level outside a frame
	txd_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_txd)
		else $error("uart_txd low while transmitter idle");

	tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else $error("tx_done high for more than one cycle");

	rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done high for more than one cycle");

	rx_error_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_error |=> !rx_error)
		else $error("rx_error high for more than one cycle");

	done_error_excl: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_error))
		else $error("rx_done and rx_error high together");

endmodule

bind uart_string_link uart_string_link_sva uart_string_link_sva_i (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.uart_txd  (uart_txd),
	.tx_busy   (tx_busy),
	.tx_done   (tx_done),
	.rx_done   (rx_done),
	.rx_error  (rx_error)
);

`default_nettype wire

// ==== vlog.f ====
design/uart_link_pkg.sv
design/uart_byte_tx.sv
design/uart_byte_rx.sv
design/frame_sender.sv
design/frame_receiver.sv
design/uart_string_link.sv
tests/tb_uart_string_link.sv
tests/uart_string_link_sva.sv

// ==== run.sh ====
#!/bin/sh
# build the string link testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_uart_string_link -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation run error, see sim.log"; exit 1; }
grep -q "sim failed" sim.log && { echo "testbench reported a failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "run clean"
exit 0
